// File: hdl/fas_consts.svh
/*
  Sizing constants for the 16-point frequency analysis pipeline.
  The stage count must equal log2 of the frame size, and the pipeline
  width must hold a full-scale sample plus one bit of growth per stage.
*/
`ifndef FAS_CONSTS_SVH
`define FAS_CONSTS_SVH

`define FAS_N_POINTS   16  // Samples per frame and bins per spectrum
`define FAS_LOG2_N     4   // Butterfly stages, also bin index width
`define FAS_SAMPLE_W   16  // Input sample width
`define FAS_ACC_W      24  // Real or imaginary part inside the pipeline

`define FAS_TW_FRAC    16  // Twiddle fraction bits, 1.0 is 65536
`define FAS_OUT_SHIFT  4   // Right shift on each output bin

`endif

// File: hdl/fas_pkg.sv
/*
  Shared data types of the frequency analysis block.
  Widths come from the constants header, so that header must be on the
  include path when this package is compiled.
*/
`include "fas_consts.svh"

package fas_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sample and pipeline types
  ////////////////////////////////////////////////////////////////////////////

  // Signed input sample as it arrives on the data port
  typedef logic signed [`FAS_SAMPLE_W-1:0] sample_t;

  // One real or imaginary part between butterfly stages
  typedef logic signed [`FAS_ACC_W-1:0] acc_t;

  ////////////////////////////////////////////////////////////////////////////
  // Output types
  ////////////////////////////////////////////////////////////////////////////

  // Packed bin, real part in the upper half and imaginary part in the lower
  typedef logic [2*`FAS_SAMPLE_W-1:0] bin_t;

  // Index of one bin in natural order
  typedef logic [`FAS_LOG2_N-1:0] bin_idx_t;

endpackage

// File: hdl/frame_collector.sv
/*
  Gathers strobed samples into a parallel frame of 16.
  Idle cycles between strobes only pause the write index. The frame stays
  on frame_re until the next sample overwrites entry 0, so the next stage
  must take it on the cycle frame_valid is high.
*/
`timescale 1ns/100ps
`include "fas_consts.svh"

module frame_collector (
  input  logic             clk,
  input  logic             rst,
  input  logic             data_valid,
  input  fas_pkg::sample_t data,
  output logic             frame_valid,
  output fas_pkg::acc_t    frame_re [`FAS_N_POINTS],
  output fas_pkg::acc_t    frame_im [`FAS_N_POINTS]
);

  import fas_pkg::*;

  logic [`FAS_LOG2_N-1:0] wr_idx;  // Slot for the next accepted sample

  ////////////////////////////////////////////////////////////////////////////
  // Write index and frame strobe
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_idx      <= '0;
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= data_valid && (&wr_idx);  // Last slot filled this edge
      if (data_valid) begin
        wr_idx <= wr_idx + 1'b1;  // Wraps to 0 after slot 15
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Sample store
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (data_valid) begin
      frame_re[wr_idx] <= acc_t'(data);  // Sign-extended into pipeline width
    end
  end

  // Real input only
  always_comb begin
    for (int i = 0; i < `FAS_N_POINTS; i++) begin
      frame_im[i] = '0;
    end
  end

endmodule

// File: hdl/butterfly_stage.sv
/*
  One registered radix-2 decimation-in-frequency stage of a 16-point FFT.
  stage_idx runs from 0 to 3; stage 0 pairs points 8 apart.
  Twiddles are Q16, and the complex products are floored to the pipeline
  width, so a product that is not exact loses its fraction toward minus
  infinity. There is no saturation on overflow.
*/
`timescale 1ns/100ps
`include "fas_consts.svh"

module butterfly_stage #(
  parameter int stage_idx = 0
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          in_valid,
  input  fas_pkg::acc_t in_re [`FAS_N_POINTS],
  input  fas_pkg::acc_t in_im [`FAS_N_POINTS],
  output logic          out_valid,
  output fas_pkg::acc_t out_re [`FAS_N_POINTS],
  output fas_pkg::acc_t out_im [`FAS_N_POINTS]
);

  import fas_pkg::*;

  localparam int HALF    = `FAS_N_POINTS / 2;
  localparam int SPAN    = HALF >> stage_idx;  // Distance between pair members
  localparam int TW_STEP = 1 << stage_idx;     // Twiddle index step within a group
  localparam int TW_W    = `FAS_TW_FRAC + 2;   // Holds +1.0 and -1.0
  localparam int DIFF_W  = `FAS_ACC_W + 1;
  localparam int PROD_W  = DIFF_W + TW_W + 1;

  // W(t) = cos(2*pi*t/16) - j*sin(2*pi*t/16), t = 0..7
  localparam logic signed [TW_W-1:0] TW_RE [HALF] = '{
    18'sd65536,  18'sd60547,  18'sd46340,  18'sd25079,
    18'sd0,     -18'sd25079, -18'sd46340, -18'sd60547
  };
  localparam logic signed [TW_W-1:0] TW_IM [HALF] = '{
    18'sd0,     -18'sd25079, -18'sd46340, -18'sd60547,
   -18'sd65536, -18'sd60547, -18'sd46340, -18'sd25079
  };

  acc_t nxt_re [`FAS_N_POINTS];
  acc_t nxt_im [`FAS_N_POINTS];

  ////////////////////////////////////////////////////////////////////////////
  // Butterflies
  ////////////////////////////////////////////////////////////////////////////

  for (genvar b = 0; b < HALF; b++) begin : g_bfly
    localparam int GRP = b / SPAN;
    localparam int M   = b % SPAN;             // Position of a inside its group
    localparam int TOP = GRP * 2 * SPAN + M;
    localparam int BOT = TOP + SPAN;
    localparam int TW  = M * TW_STEP;

    logic signed [DIFF_W-1:0] d_re, d_im;
    logic signed [PROD_W-1:0] p_re, p_im;

    assign d_re = in_re[TOP] - in_re[BOT];
    assign d_im = in_im[TOP] - in_im[BOT];

    // Complex multiply by the stage twiddle
    assign p_re = d_re * TW_RE[TW] - d_im * TW_IM[TW];
    assign p_im = d_re * TW_IM[TW] + d_im * TW_RE[TW];

    assign nxt_re[TOP] = in_re[TOP] + in_re[BOT];
    assign nxt_im[TOP] = in_im[TOP] + in_im[BOT];
    assign nxt_re[BOT] = p_re[`FAS_TW_FRAC +: `FAS_ACC_W];  // Floor of Q16 product
    assign nxt_im[BOT] = p_im[`FAS_TW_FRAC +: `FAS_ACC_W];
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      out_re <= nxt_re;
      out_im <= nxt_im;
    end
  end

endmodule

// File: hdl/spectrum_drain.sv
/*
  Output side of the FFT pipeline.
  Bins leave stage 3 in bit-reversed order; they are put back in natural
  order, divided by 16 and truncated to 16-bit parts with no saturation.
  The peak search runs one cycle later on the packed bins, lowest index
  wins a tie, and freq holds until the next frame.
*/
`timescale 1ns/100ps
`include "fas_consts.svh"

module spectrum_drain (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid,
  input  fas_pkg::acc_t     in_re [`FAS_N_POINTS],
  input  fas_pkg::acc_t     in_im [`FAS_N_POINTS],
  output logic              fft_valid,
  output fas_pkg::bin_t     fft_d [`FAS_N_POINTS],
  output logic              done,
  output fas_pkg::bin_idx_t freq
);

  import fas_pkg::*;

  localparam int SW    = `FAS_SAMPLE_W;
  localparam int MAG_W = 2 * SW + 1;  // Sum of two full-scale squares

  function automatic int bit_rev(input int v);
    int r;
    r = 0;
    for (int k = 0; k < `FAS_LOG2_N; k++) begin
      r = (r << 1) | ((v >> k) & 1);
    end
    return r;
  endfunction

  bin_t             nxt_bin [`FAS_N_POINTS];
  logic [MAG_W-1:0] mag     [`FAS_N_POINTS];
  bin_idx_t         best_idx;
  logic [MAG_W-1:0] best_mag;

  ////////////////////////////////////////////////////////////////////////////
  // Reorder, scale and pack
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `FAS_N_POINTS; i++) begin : g_bin
    localparam int SRC = bit_rev(i);

    logic signed [SW-1:0] b_re, b_im;

    // Arithmetic shift then truncate to the output width
    assign nxt_bin[i] = {in_re[SRC][`FAS_OUT_SHIFT +: SW],
                         in_im[SRC][`FAS_OUT_SHIFT +: SW]};

    assign b_re = fft_d[i][2*SW-1:SW];  // Magnitude taken on registered bins
    assign b_im = fft_d[i][SW-1:0];
    assign mag[i] = b_re * b_re + b_im * b_im;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fft_valid <= 1'b0;
      for (int i = 0; i < `FAS_N_POINTS; i++) begin
        fft_d[i] <= '0;
      end
    end else begin
      fft_valid <= in_valid;
      if (in_valid) begin
        fft_d <= nxt_bin;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Peak bin search
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    best_idx = '0;
    best_mag = mag[0];
    for (int i = 1; i < `FAS_N_POINTS; i++) begin
      if (mag[i] > best_mag) begin  // Strict compare keeps the lower index
        best_idx = bin_idx_t'(i);
        best_mag = mag[i];
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      done <= 1'b0;
      freq <= '0;
    end else begin
      done <= fft_valid;
      if (fft_valid) begin
        freq <= best_idx;
      end
    end
  end

endmodule

// File: hdl/fas_top.sv
/*
  Frequency analysis top level: frame collector, four FFT stages and the
  spectrum drain. A frame may start every 16 accepted samples; fft_valid
  follows the edge of the 16th sample by 5 cycles and done by 6.
  There is no back-pressure, so results must be taken when they pulse.
*/
`timescale 1ns/100ps
`include "fas_consts.svh"

module fas_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              data_valid,
  input  fas_pkg::sample_t  data,
  output logic              fft_valid,
  output fas_pkg::bin_t     fft_d [`FAS_N_POINTS],
  output logic              done,
  output fas_pkg::bin_idx_t freq
);

  import fas_pkg::*;

  // Boundary k feeds stage k; boundary 4 feeds the drain
  logic stage_valid [`FAS_LOG2_N+1];
  acc_t stage_re    [`FAS_LOG2_N+1][`FAS_N_POINTS];
  acc_t stage_im    [`FAS_LOG2_N+1][`FAS_N_POINTS];

  frame_collector u_collector (
    .clk         (clk),
    .rst         (rst),
    .data_valid  (data_valid),
    .data        (data),
    .frame_valid (stage_valid[0]),
    .frame_re    (stage_re[0]),
    .frame_im    (stage_im[0])
  );

  ////////////////////////////////////////////////////////////////////////////
  // FFT stages
  ////////////////////////////////////////////////////////////////////////////

  for (genvar k = 0; k < `FAS_LOG2_N; k++) begin : g_stage
    butterfly_stage #(
      .stage_idx (k)
    ) u_stage (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (stage_valid[k]),
      .in_re     (stage_re[k]),
      .in_im     (stage_im[k]),
      .out_valid (stage_valid[k+1]),
      .out_re    (stage_re[k+1]),
      .out_im    (stage_im[k+1])
    );
  end

  spectrum_drain u_drain (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (stage_valid[`FAS_LOG2_N]),
    .in_re     (stage_re[`FAS_LOG2_N]),
    .in_im     (stage_im[`FAS_LOG2_N]),
    .fft_valid (fft_valid),
    .fft_d     (fft_d),
    .done      (done),
    .freq      (freq)
  );

endmodule

// File: testbench/fas_tb.sv
/*
  Testbench for fas_top, driven from testbench/fas_tests.txt.
  The data file path is relative to the project root, so the run starts there.
  Expected bins hold only for frames whose twiddle products are exact.
*/
`timescale 1ns/100ps
`include "fas_consts.svh"

module fas_tb;

  import fas_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int NPTS       = `FAS_N_POINTS;
  localparam int MAX_REC    = 32;
  localparam int REC_WORDS  = 2 * NPTS + 2;  // Mode, samples, bins and peak
  localparam int MODE_BURST = 0;
  localparam int MODE_GAP   = 1;
  localparam int MODE_RESET = 2;

  logic     clk = 1'b0;
  logic     rst;
  logic     data_valid;
  sample_t  data;
  logic     fft_valid;
  bin_t     fft_d [NPTS];
  logic     done;
  bin_idx_t freq;

  // Test records as read from the data file
  logic [31:0] words    [1 + MAX_REC * REC_WORDS];
  int          n_rec;
  int          rec_mode [MAX_REC];
  sample_t     rec_smp  [MAX_REC][NPTS];
  bin_t        rec_bin  [MAX_REC][NPTS];
  bin_idx_t    rec_peak [MAX_REC];

  int pending_q [$];  // Records whose bins are still due in send order
  int frames_sent;
  int frames_checked;
  int done_rec;
  bit done_due;       // Set when fft_valid is seen and done is due next cycle
  bit loaded;

  fas_top dut (
    .clk        (clk),
    .rst        (rst),
    .data_valid (data_valid),
    .data       (data),
    .fft_valid  (fft_valid),
    .fft_d      (fft_d),
    .done       (done),
    .freq       (freq)
  );

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_bin(input int idx, input bin_t exp_val, input bin_t act_val);
    if (act_val !== exp_val) begin
      stop_run($sformatf("Fail at %0d ns: fft_d[%0d] expected %h, got %h",
                         $time, idx, exp_val, act_val));
    end
  endtask

  task automatic check_freq(input bin_idx_t exp_val, input bin_idx_t act_val);
    if (act_val !== exp_val) begin
      stop_run($sformatf("Fail at %0d ns: freq expected %0d, got %0d",
                         $time, exp_val, act_val));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers called on a falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_tests();
    int w;
    $readmemh("testbench/fas_tests.txt", words);
    n_rec = int'(words[0]);
    if (n_rec < 1 || n_rec > MAX_REC) begin
      stop_run("The tests file is missing or its record count is out of range");
    end else begin
      w = 1;
      for (int r = 0; r < n_rec; r++) begin
        rec_mode[r] = int'(words[w]);
        w++;
        for (int i = 0; i < NPTS; i++) rec_smp[r][i] = sample_t'(words[w + i]);
        w += NPTS;
        for (int i = 0; i < NPTS; i++) rec_bin[r][i] = bin_t'(words[w + i]);
        w += NPTS;
        rec_peak[r] = bin_idx_t'(words[w]);
        w++;
      end
    end
  endtask

  task automatic apply_reset();
    rst        = 1'b1;
    data_valid = 1'b0;
    repeat (3) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic send_sample(input sample_t s);
    data       = s;
    data_valid = 1'b1;
    @(negedge clk);
    data_valid = 1'b0;
  endtask

  task automatic send_frame(input int r, input bit gapped);
    int gap;
    for (int i = 0; i < NPTS; i++) begin
      if (gapped) begin
        gap = int'($urandom % 4);  // 0 to 3 idle cycles
        repeat (gap) @(negedge clk);
      end
      if (i == NPTS - 1) begin
        pending_q.push_back(r);
        frames_sent++;
      end
      send_sample(rec_smp[r][i]);
    end
  endtask

  task automatic wait_results();
    while (frames_checked != frames_sent || done_due) begin
      @(negedge clk);
    end
  endtask

  // Stray samples, then reset, then the real frame
  task automatic reset_mid_frame(input int r);
    int n_stray;
    wait_results();
    n_stray = 1 + int'($urandom % 15);  // Never a full frame
    for (int i = 0; i < n_stray; i++) begin
      send_sample(sample_t'($urandom));
    end
    apply_reset();
    repeat (8) @(negedge clk);  // Monitor flags any fft_valid or done here
    send_frame(r, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Result monitor sampling half a cycle after outputs change
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin : result_monitor
    int rec;
    if (done_due) begin
      if (done !== 1'b1) stop_run("done did not follow fft_valid by one cycle");
      check_freq(rec_peak[done_rec], freq);
      done_due = 1'b0;
    end else if (done !== 1'b0) begin
      stop_run($sformatf("done was high at %0d ns with no fft_valid before it", $time));
    end
    if (fft_valid === 1'b1) begin
      if (pending_q.size() == 0) begin
        stop_run($sformatf("fft_valid was high at %0d ns with no frame sent", $time));
      end else begin
        rec = pending_q.pop_front();
        for (int i = 0; i < NPTS; i++) check_bin(i, rec_bin[rec][i], fft_d[i]);
        done_rec = rec;
        done_due = 1'b1;
        frames_checked++;
      end
    end else if (fft_valid !== 1'b0) begin
      stop_run("fft_valid is neither high nor low");
    end
  end

  initial begin : watchdog
    int limit;
    wait (loaded);
    limit = n_rec * 40 + 100;
    repeat (limit) @(posedge clk);
    $display("Timeout after %0d cycles: the results never arrived", limit);
    $display("RESULT: FAIL");
    $fatal(1, "Watchdog expired");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    rst        = 1'b1;
    data_valid = 1'b0;
    data       = '0;
    void'($urandom(32'h30c3));
    load_tests();
    loaded = 1'b1;
    apply_reset();
    for (int r = 0; r < n_rec; r++) begin
      case (rec_mode[r])
        MODE_BURST: send_frame(r, 1'b0);  // Follows the previous frame directly
        MODE_GAP:   send_frame(r, 1'b1);
        MODE_RESET: reset_mid_frame(r);
        default:    stop_run($sformatf("Record %0d has unknown mode %0d", r, rec_mode[r]));
      endcase
    end
    wait_results();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: testbench/fas_tests.txt
// First word is the record count. Each record is a mode (0 back to back,
// 1 gapped, 2 reset mid-frame), 16 samples, 16 bins as {re, im}, the peak bin
8
0  // Impulse of 1600 leading three back-to-back frames
0640 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
00640000 00640000 00640000 00640000 00640000 00640000 00640000 00640000
00640000 00640000 00640000 00640000 00640000 00640000 00640000 00640000
0
0  // Constant 160
00a0 00a0 00a0 00a0 00a0 00a0 00a0 00a0 00a0 00a0 00a0 00a0 00a0 00a0 00a0 00a0
00a00000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
0
0  // Alternating sign of amplitude 1000
03e8 fc18 03e8 fc18 03e8 fc18 03e8 fc18 03e8 fc18 03e8 fc18 03e8 fc18 03e8 fc18
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
03e80000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
8
1  // Quarter-rate cosine of amplitude 2000 with idle gaps
07d0 0000 f830 0000 07d0 0000 f830 0000 07d0 0000 f830 0000 07d0 0000 f830 0000
00000000 00000000 00000000 00000000 03e80000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 03e80000 00000000 00000000 00000000
4
0  // Same cosine without gaps
07d0 0000 f830 0000 07d0 0000 f830 0000 07d0 0000 f830 0000 07d0 0000 f830 0000
00000000 00000000 00000000 00000000 03e80000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 03e80000 00000000 00000000 00000000
4
2  // Quarter-rate sine after a reset in a partial frame
0000 07d0 0000 f830 0000 07d0 0000 f830 0000 07d0 0000 f830 0000 07d0 0000 f830
00000000 00000000 00000000 00000000 0000fc18 00000000 00000000 00000000
00000000 00000000 00000000 00000000 000003e8 00000000 00000000 00000000
4
1  // Bins 0 and 8 tie in magnitude
0000 00c8 0000 00c8 0000 00c8 0000 00c8 0000 00c8 0000 00c8 0000 00c8 0000 00c8
00640000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
ff9c0000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
0
2  // Impulse of -24 where the output shift floors to -2
ffe8 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
fffe0000 fffe0000 fffe0000 fffe0000 fffe0000 fffe0000 fffe0000 fffe0000
fffe0000 fffe0000 fffe0000 fffe0000 fffe0000 fffe0000 fffe0000 fffe0000
0

// File: verilog.f
+incdir+hdl
hdl/fas_pkg.sv
hdl/frame_collector.sv
hdl/butterfly_stage.sv
hdl/spectrum_drain.sv
hdl/fas_top.sv
testbench/fas_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds fas_tb with Verilator, runs it, and passes only on the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module fas_tb \
  -f verilog.f -o fas_sim || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/fas_sim 2>&1)
echo "$sim_out"

echo "$sim_out" | grep -qx "RESULT: PASS" && echo "Simulation passed" || {
  echo "Simulation failed"
  exit 1
}
